//--- all.f
+incdir+rtl
rtl/lc3_pkg.sv
rtl/lc3_regfile.sv
rtl/lc3_alu.sv
rtl/lc3_datapath.sv
rtl/lc3_ctrl.sv
rtl/lc3_mem_port.sv
rtl/lc3_top.sv
tb/lc3_properties.sv
tb/lc3_tb.sv

//--- Makefile
# Verilator build and run for the LC-3 core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lc3_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/lc3_tb.sv
// LC-3 core testbench
// Table-loaded memory behind a Wishbone slave with random ack delay,
// checks each store against hand-worked results

`timescale 1ns/1ps

`include "lc3_settings.svh"

module lc3_tb;
    import lc3_pkg::*;

    localparam int    num_prog    = 25;
    localparam int    num_stores  = 9;
    localparam int    num_instr   = 23;               // executed path without skipped words
    localparam int    cycle_limit = num_instr * 16;
    localparam word_t data_adr    = 16'h3040;
    localparam word_t data_val    = 16'h1234;
    localparam word_t jmp_adr     = 16'h3010;
    localparam word_t jmp_target  = 16'h3012;         // LEA R7 result

    // --------------------
    // program at the reset PC
    localparam word_t program_words [num_prog] = '{
        16'h223F,   // LD   R1, x3040       R1 = 1234, P
        16'h147D,   // ADD  R2, R1, #-3     R2 = 1231
        16'h1642,   // ADD  R3, R1, R2      R3 = 2465
        16'h344C,   // ST   R2, x3050
        16'h364C,   // ST   R3, x3051
        16'h58EF,   // AND  R4, R3, #15     R4 = 0005
        16'h9A7F,   // NOT  R5, R1          R5 = EDCB
        16'h384A,   // ST   R4, x3052
        16'h3A4A,   // ST   R5, x3053
        16'h5C45,   // AND  R6, R1, R5      R6 = 0000, Z
        16'h0A01,   // BRnp x300C           not taken
        16'h3C48,   // ST   R6, x3054
        16'h0401,   // BRz  x300E           taken
        16'h3247,   // ST   R1, x3055       skipped
        16'hEE03,   // LEA  R7, x3012
        16'h3E46,   // ST   R7, x3056
        16'hC1C0,   // JMP  R7
        16'h3245,   // ST   R1, x3057       skipped
        16'h1161,   // ADD  R0, R5, #1      R0 = EDCC, N
        16'h0201,   // BRp  x3015           not taken
        16'h3043,   // ST   R0, x3058
        16'hE7FA,   // LEA  R3, x3010       negative offset
        16'h3642,   // ST   R3, x3059
        16'hF025,   // TRAP runs as no-op
        16'h3241    // ST   R1, x305A
    };

    // expected stores in order as address and data
    localparam word_t store_table [num_stores][2] = '{
        '{16'h3050, 16'h1231}, '{16'h3051, 16'h2465}, '{16'h3052, 16'h0005},
        '{16'h3053, 16'hEDCB}, '{16'h3054, 16'h0000}, '{16'h3056, 16'h3012},
        '{16'h3058, 16'hEDCC}, '{16'h3059, 16'h3010}, '{16'h305A, 16'h1234}
    };

    logic   clk;
    logic   rst_n;
    logic   wb_cyc, wb_stb, wb_we, wb_ack;
    word_t  wb_adr, wb_dat_wr, wb_dat_rd;
    word_t  mem [65536];
    word_t  store_adr_q [$];
    word_t  store_dat_q [$];
    word_t  first_read_adr;
    word_t  jmp_next_adr;
    logic   first_read_seen = 1'b0;
    logic   after_jmp = 1'b0;
    integer seed = 41125;
    int     cycle_count;

    lc3_top i_lc3_top (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_wr(wb_dat_wr), .wb_dat_rd(wb_dat_rd), .wb_ack(wb_ack)
    );

    bind lc3_top lc3_properties i_properties (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic serve_access();
        if (wb_we) begin
            mem[wb_adr] = wb_dat_wr;
            store_adr_q.push_back(wb_adr);
            store_dat_q.push_back(wb_dat_wr);
        end else begin
            wb_dat_rd = mem[wb_adr];
            if (!first_read_seen) begin
                first_read_adr  = wb_adr;
                first_read_seen = 1'b1;
            end
            if (after_jmp) begin
                jmp_next_adr = wb_adr;       // fetch right after the JMP word
                after_jmp    = 1'b0;
            end else if (wb_adr == jmp_adr) begin
                after_jmp = 1'b1;
            end
        end
    endtask

    // --------------------
    // Wishbone slave with 0 to 3 wait cycles per transfer
    initial begin : wb_slave
        int unsigned wait_left;
        logic        busy;
        wb_ack    = 1'b0;
        wb_dat_rd = '0;
        wait_left = 0;
        busy      = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;                // cycle closed on this edge
                busy   = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4;
                end
                if (wait_left == 0) begin
                    serve_access();
                    wb_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: program did not finish within %0d cycles", cycle_limit);
                $display("Something failed");
                $fatal(1, "simulation timed out");
            end
        end
    end

    // --------------------
    // reset, preload, store checks
    initial begin : main
        word_t got_adr;
        word_t got_dat;
        rst_n        = 1'b0;
        jmp_next_adr = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = word_t'(a) ^ 16'hC35A;   // unique per address
        end
        for (int i = 0; i < num_prog; i++) begin
            mem[word_t'(`LC3_RESET_PC + i)] = program_words[i];
        end
        mem[data_adr] = data_val;

        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("wb_cyc", word_t'(wb_cyc), '0);
        end
        rst_n = 1'b1;

        while (!first_read_seen) @(posedge clk);
        check_value("wb_adr", first_read_adr, `LC3_RESET_PC);

        for (int i = 0; i < num_stores; i++) begin
            while (store_adr_q.size() == 0) @(posedge clk);
            got_adr = store_adr_q.pop_front();
            got_dat = store_dat_q.pop_front();
            check_value("wb_adr", got_adr, store_table[i][0]);
            check_value("wb_dat_wr", got_dat, store_table[i][1]);
        end

        check_value("wb_adr", jmp_next_adr, jmp_target);
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/lc3_properties.sv
// Wishbone master checks for the LC-3 core
// Strobe only inside a cycle, request held while waiting, bus quiet in reset

`timescale 1ns/1ps

module lc3_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input logic           wb_ack,
    input lc3_pkg::word_t wb_adr,
    input lc3_pkg::word_t wb_dat_wr
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // request must not move until the slave acks
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_wr)))
        else $error("Wishbone request changed while waiting for ack");

    no_cyc_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_cyc)
        else $error("wb_cyc high during reset");

endmodule

//--- rtl/lc3_top.sv
// LC-3 core top level
// Controller, datapath and Wishbone memory port around one shared bus

`timescale 1ns/1ps

module lc3_top (
    input  logic           clk,
    input  logic           rst_n,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output lc3_pkg::word_t wb_adr,
    output lc3_pkg::word_t wb_dat_wr,
    input  lc3_pkg::word_t wb_dat_rd,
    input  logic           wb_ack
);
    import lc3_pkg::*;

    // --------------------
    // control strobes
    logic     ld_ir, ld_cc, ld_reg, ld_mar, ld_mdr, ld_pc;
    logic     mem_req, mem_we, mem_done;
    bus_src_e bus_src;
    pc_src_e  pc_src;

    // --------------------
    // data
    instr_u   ir;
    word_t    bus;
    word_t    mdr;
    logic     branch_taken;

    lc3_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .ir(ir), .branch_taken(branch_taken),
        .mem_done(mem_done), .ld_ir(ld_ir), .ld_cc(ld_cc), .ld_reg(ld_reg),
        .ld_mar(ld_mar), .ld_mdr(ld_mdr), .ld_pc(ld_pc), .mem_req(mem_req),
        .mem_we(mem_we), .bus_src(bus_src), .pc_src(pc_src)
    );

    lc3_datapath u_datapath (
        .clk(clk), .rst_n(rst_n), .ld_ir(ld_ir), .ld_cc(ld_cc), .ld_reg(ld_reg),
        .ld_pc(ld_pc), .bus_src(bus_src), .pc_src(pc_src), .mdr(mdr),
        .ir(ir), .bus(bus), .branch_taken(branch_taken)
    );

    lc3_mem_port u_mem_port (
        .clk(clk), .rst_n(rst_n), .ld_mar(ld_mar), .ld_mdr(ld_mdr),
        .mem_req(mem_req), .mem_we(mem_we), .bus(bus),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_wr(wb_dat_wr), .wb_dat_rd(wb_dat_rd), .wb_ack(wb_ack),
        .mdr(mdr), .mem_done(mem_done)
    );

endmodule

//--- rtl/lc3_mem_port.sv
// LC-3 memory port
// MAR and MDR plus a single-word Wishbone classic master cycle per request

`timescale 1ns/1ps

module lc3_mem_port (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ld_mar,
    input  logic           ld_mdr,
    input  logic           mem_req,
    input  logic           mem_we,
    input  lc3_pkg::word_t bus,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output lc3_pkg::word_t wb_adr,
    output lc3_pkg::word_t wb_dat_wr,
    input  lc3_pkg::word_t wb_dat_rd,
    input  logic           wb_ack,
    output lc3_pkg::word_t mdr,
    output logic           mem_done
);
    import lc3_pkg::*;

    word_t mar;
    logic  cyc_q;

    // --------------------
    // bus cycle control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
            wb_we <= 1'b0;
        end else if (mem_done) begin
            cyc_q <= 1'b0;                // all drop after ack
            wb_we <= 1'b0;
        end else if (mem_req) begin
            cyc_q <= 1'b1;
            wb_we <= mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_mar) mar <= bus;
        if (ld_mdr) mdr <= bus;
        else if (mem_done && !wb_we) mdr <= wb_dat_rd;  // read data
    end

    assign wb_cyc    = cyc_q;
    assign wb_stb    = cyc_q;
    assign wb_adr    = mar;
    assign wb_dat_wr = mdr;
    assign mem_done  = cyc_q & wb_ack;

endmodule

//--- rtl/lc3_ctrl.sv
// LC-3 instruction sequencer
// Fetch, decode and per-opcode execute states driving the load strobes
// and bus/PC selects; unknown opcodes fall back to fetch

`timescale 1ns/1ps

module lc3_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  lc3_pkg::instr_u   ir,
    input  logic              branch_taken,
    input  logic              mem_done,
    output logic              ld_ir,
    output logic              ld_cc,
    output logic              ld_reg,
    output logic              ld_mar,
    output logic              ld_mdr,
    output logic              ld_pc,
    output logic              mem_req,
    output logic              mem_we,
    output lc3_pkg::bus_src_e bus_src,
    output lc3_pkg::pc_src_e  pc_src
);
    import lc3_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_FETCH, S_FETCH_WAIT, S_LOAD_IR, S_DECODE,
        S_EXEC_ALU, S_EXEC_LEA, S_EXEC_BR, S_EXEC_JMP,
        S_LD_ADDR, S_LD_WAIT, S_LD_WB, S_ST_ADDR, S_ST_WAIT
    } state_e;

    state_e state_q, state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;            // strobes quiet out of reset
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // next state and strobes
    always_comb begin
        state_d = state_q;
        ld_ir   = 1'b0;
        ld_cc   = 1'b0;
        ld_reg  = 1'b0;
        ld_mar  = 1'b0;
        ld_mdr  = 1'b0;
        ld_pc   = 1'b0;
        mem_req = 1'b0;
        mem_we  = 1'b0;
        bus_src = BUS_PC;
        pc_src  = PC_INC;
        case (state_q)
            S_IDLE: state_d = S_FETCH;
            S_FETCH: begin
                ld_mar  = 1'b1;           // MAR <- PC
                mem_req = 1'b1;
                state_d = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: if (mem_done) state_d = S_LOAD_IR;
            S_LOAD_IR: begin
                bus_src = BUS_MDR;
                ld_ir   = 1'b1;
                ld_pc   = 1'b1;           // PC + 1
                state_d = S_DECODE;
            end
            S_DECODE: begin
                case (ir.op.opcode)
                    OP_ADD, OP_AND, OP_NOT: state_d = S_EXEC_ALU;
                    OP_LEA: state_d = S_EXEC_LEA;
                    OP_BR:  state_d = S_EXEC_BR;
                    OP_JMP: state_d = S_EXEC_JMP;
                    OP_LD:  state_d = S_LD_ADDR;
                    OP_ST: begin
                        // source register passes through the ALU
                        bus_src = BUS_ALU;
                        ld_mdr  = 1'b1;
                        state_d = S_ST_ADDR;
                    end
                    default: state_d = S_FETCH;
                endcase
            end
            S_EXEC_ALU: begin
                bus_src = BUS_ALU;
                ld_reg  = 1'b1;
                ld_cc   = 1'b1;
                state_d = S_FETCH;
            end
            S_EXEC_LEA: begin
                bus_src = BUS_EA;
                ld_reg  = 1'b1;
                ld_cc   = 1'b1;
                state_d = S_FETCH;
            end
            S_EXEC_BR: begin
                pc_src  = PC_EA;
                ld_pc   = branch_taken;
                state_d = S_FETCH;
            end
            S_EXEC_JMP: begin
                pc_src  = PC_SR1;
                ld_pc   = 1'b1;
                state_d = S_FETCH;
            end
            S_LD_ADDR: begin
                bus_src = BUS_EA;
                ld_mar  = 1'b1;
                mem_req = 1'b1;
                state_d = S_LD_WAIT;
            end
            S_LD_WAIT: if (mem_done) state_d = S_LD_WB;
            S_LD_WB: begin
                bus_src = BUS_MDR;
                ld_reg  = 1'b1;
                ld_cc   = 1'b1;
                state_d = S_FETCH;
            end
            S_ST_ADDR: begin
                bus_src = BUS_EA;
                ld_mar  = 1'b1;
                mem_req = 1'b1;
                mem_we  = 1'b1;
                state_d = S_ST_WAIT;
            end
            S_ST_WAIT: if (mem_done) state_d = S_FETCH;
            default: state_d = S_FETCH;
        endcase
    end

endmodule

//--- rtl/lc3_datapath.sv
// LC-3 datapath
// Shared bus mux, IR, N/Z/P flags, PC with effective-address adder,
// plus the register file and ALU

`timescale 1ns/1ps

`include "lc3_settings.svh"

module lc3_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ld_ir,
    input  logic              ld_cc,
    input  logic              ld_reg,
    input  logic              ld_pc,
    input  lc3_pkg::bus_src_e bus_src,
    input  lc3_pkg::pc_src_e  pc_src,
    input  lc3_pkg::word_t    mdr,
    output lc3_pkg::instr_u   ir,
    output lc3_pkg::word_t    bus,
    output logic              branch_taken
);
    import lc3_pkg::*;

    word_t    pc;
    word_t    ea;
    word_t    alu_result;
    word_t    sr1_data, sr2_data;
    reg_idx_t sr1_idx;
    logic     flag_n, flag_z, flag_p;

    assign ea = pc + {{(`LC3_WORD_W-9){ir.off.pcoffset9[8]}}, ir.off.pcoffset9};

    // ST reads its source from the dr field
    assign sr1_idx = (ir.op.opcode == OP_ST) ? ir.op.dr : ir.op.sr1;

    always_comb begin
        case (bus_src)
            BUS_PC:  bus = pc;
            BUS_MDR: bus = mdr;
            BUS_ALU: bus = alu_result;
            default: bus = ea;
        endcase
    end

    // --------------------
    // IR, PC and flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir     <= '0;
            pc     <= `LC3_RESET_PC;
            flag_n <= 1'b0;
            flag_z <= 1'b1;
            flag_p <= 1'b0;
        end else begin
            if (ld_ir) ir <= bus;
            if (ld_pc) begin
                case (pc_src)
                    PC_INC:  pc <= pc + 1'b1;
                    PC_EA:   pc <= ea;
                    PC_SR1:  pc <= sr1_data;
                    default: pc <= pc;
                endcase
            end
            if (ld_cc) begin
                flag_n <= bus[`LC3_WORD_W-1];
                flag_z <= (bus == '0);
                flag_p <= !bus[`LC3_WORD_W-1] && (bus != '0);
            end
        end
    end

    assign branch_taken = |(ir.off.dr_nzp & {flag_n, flag_z, flag_p});

    lc3_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .ld_reg(ld_reg), .dr(ir.op.dr),
        .sr1(sr1_idx), .sr2(ir.op.imm5[2:0]), .wr_data(bus),
        .sr1_data(sr1_data), .sr2_data(sr2_data)
    );

    lc3_alu u_alu (
        .op(ir.op.opcode), .ir(ir), .sr1_data(sr1_data), .sr2_data(sr2_data),
        .result(alu_result)
    );

endmodule

//--- rtl/lc3_alu.sv
// LC-3 ALU
// ADD, AND and NOT on sr1 with a register or sign-extended imm5 operand

`timescale 1ns/1ps

module lc3_alu (
    input  lc3_pkg::opcode_e op,
    input  lc3_pkg::instr_u  ir,
    input  lc3_pkg::word_t   sr1_data,
    input  lc3_pkg::word_t   sr2_data,
    output lc3_pkg::word_t   result
);
    import lc3_pkg::*;

    word_t operand_b;

    assign operand_b = ir.op.imm_flag ? word_t'({{11{ir.op.imm5[4]}}, ir.op.imm5}) : sr2_data;

    always_comb begin
        case (op)
            OP_ADD:  result = sr1_data + operand_b;
            OP_AND:  result = sr1_data & operand_b;
            OP_NOT:  result = ~sr1_data;
            default: result = sr1_data;   // pass, used by ST
        endcase
    end

endmodule

//--- rtl/lc3_regfile.sv
// LC-3 general register file
// Eight registers, two combinational read ports, one clocked write port

`timescale 1ns/1ps

`include "lc3_settings.svh"

module lc3_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ld_reg,
    input  lc3_pkg::reg_idx_t dr,
    input  lc3_pkg::reg_idx_t sr1,
    input  lc3_pkg::reg_idx_t sr2,
    input  lc3_pkg::word_t    wr_data,
    output lc3_pkg::word_t    sr1_data,
    output lc3_pkg::word_t    sr2_data
);
    import lc3_pkg::*;

    word_t regs [`LC3_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3_REG_COUNT; i++) regs[i] <= '0;
        end else if (ld_reg) begin
            regs[dr] <= wr_data;
        end
    end

    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule

//--- rtl/lc3_pkg.sv
// LC-3 shared types
// Machine word, instruction views and the datapath select encodings

`include "lc3_settings.svh"

package lc3_pkg;

    typedef logic [`LC3_WORD_W-1:0] word_t;
    typedef logic [2:0] reg_idx_t;

    // kept subset only, other codes run as no-op
    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_AND = 4'b0101,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_e;

    // --------------------
    // instruction word views

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   dr;
        reg_idx_t   sr1;                  // also JMP base register
        logic       imm_flag;
        logic [4:0] imm5;                 // low bits double as sr2
    } instr_op_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] dr_nzp;               // dr, sr for ST, nzp for BR
        logic [8:0] pcoffset9;
    } instr_off_t;

    typedef union packed {
        instr_op_t  op;
        instr_off_t off;
    } instr_u;

    typedef enum logic [1:0] {BUS_PC, BUS_MDR, BUS_ALU, BUS_EA} bus_src_e;
    typedef enum logic [1:0] {PC_INC, PC_EA, PC_SR1} pc_src_e;

endpackage

//--- rtl/lc3_settings.svh
// LC-3 core settings
// Word width, register file size and the PC value after reset

`ifndef LC3_SETTINGS_SVH
`define LC3_SETTINGS_SVH

// machine word, data and address
`define LC3_WORD_W 16

`define LC3_REG_COUNT 8

// first fetch address
`define LC3_RESET_PC 16'h3000

`endif
